//--- all.f
+incdir+verification
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_bypass.sv
logic/exu_redirect.sv
logic/exu_trap_regs.sv
logic/exu_top.sv
verification/exu_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run the exu testbench.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module exu_tb -f all.f -o exu_sim

out=$(./obj_dir/exu_sim)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

//--- verification/exu_model.svh
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

hist_entry_t [hist_depth-1:0] m_hist;      // index 0 is the youngest write.
logic [xlen-1:0]              m_rf [32];
logic                         m_redir;
logic [xlen-1:0]              m_mtvec;
logic [xlen-1:0]              m_mepc;
logic [xlen-1:0]              m_redirects;

task automatic model_reset();
    m_hist      = '0;
    m_redir     = 1'b0;
    m_mtvec     = '0;
    m_mepc      = '0;
    m_redirects = '0;
    m_rf[0]     = '0;
    for (int i = 1; i < 32; i++) begin
        m_rf[i] = $urandom;
    end
endtask

function automatic logic [xlen-1:0] alu_model(
    input alu_op_e         op,
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b
);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        add:     return a + b;
        sub:     return a - b;
        sll:     return a << sh;
        slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        sltu:    return (a < b) ? 32'd1 : 32'd0;
        xor_op:  return a ^ b;
        srl:     return a >> sh;
        sra:     return $unsigned($signed(a) >>> sh);
        or_op:   return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic cmp_model(
    input cmp_op_e         op,
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b
);
    case (op)
        eq:      return a == b;
        ne:      return a != b;
        lt:      return $signed(a) < $signed(b);
        ge:      return $signed(a) >= $signed(b);
        ltu:     return a < b;
        default: return a >= b;
    endcase
endfunction

// youngest write to rs, else the register file.
function automatic logic [xlen:0] operand(input logic [reg_addr_w-1:0] rs);
    for (int i = 0; i < hist_depth; i++) begin
        if (m_hist[i].valid && m_hist[i].rd == rs && rs != '0) begin
            return {m_hist[i].pending, m_hist[i].data};
        end
    end
    return {1'b0, m_rf[rs]};
endfunction

function automatic logic hist_has_pending();
    for (int i = 0; i < hist_depth; i++) begin
        if (m_hist[i].valid && m_hist[i].pending) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic fill_load(input logic [xlen-1:0] data);
    logic done;
    done = 1'b0;
    for (int i = hist_depth - 1; i >= 0; i--) begin
        if (!done && m_hist[i].valid && m_hist[i].pending) begin
            m_hist[i].data    = data;
            m_hist[i].pending = 1'b0;
            done              = 1'b1;
        end
    end
endtask

task automatic push_hist(
    input logic [reg_addr_w-1:0] rd,
    input logic [xlen-1:0]       data,
    input logic                  is_load
);
    if (m_hist[hist_depth-1].valid && m_hist[hist_depth-1].rd != '0) begin
        m_rf[m_hist[hist_depth-1].rd] = m_hist[hist_depth-1].data; // retires to the rf.
    end
    for (int i = hist_depth - 1; i > 0; i--) begin
        m_hist[i] = m_hist[i-1];
    end
    m_hist[0].valid   = 1'b1;
    m_hist[0].rd      = rd;
    m_hist[0].data    = is_load ? '0 : data;
    m_hist[0].pending = is_load;
endtask

`endif

//--- verification/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int n_instr = 400;
    localparam int seed    = 69357;

    logic            clk;
    logic            rst;
    logic            issue_valid;
    exu_issue_t      issue;
    logic            issue_ready;
    logic            res_valid;
    exu_result_t     res;
    logic            res_ready;
    logic            load_valid;
    logic [xlen-1:0] load_data;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic            redirect_ack;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] paddr;
    logic [xlen-1:0] pwdata;
    logic [xlen-1:0] prdata;
    logic            pready;
    logic            pslverr;

    exu_result_t     exp_q [$];
    logic [xlen-1:0] redir_q [$];
    exu_issue_t      cand;
    exu_result_t     held;
    logic            holding;
    logic            have_cand;
    logic            stream_on;
    logic [xlen-1:0] next_pc;
    int              loads_out;   // loads handed to memory, not yet returned.
    int              issued;
    int              checks;
    int              errors;

    `include "exu_model.svh"

    exu_top i_exu_top (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .res_valid(res_valid), .res(res), .res_ready(res_ready),
        .load_valid(load_valid), .load_data(load_data),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .redirect_ack(redirect_ack),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic check_result(input string name, input exu_result_t exp, input exu_result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_redirect(input string name, input logic [xlen-1:0] exp,
                                  input logic [xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_apb(input string name, input logic [xlen-1:0] exp,
                             input logic [xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic exu_issue_t gen_instr(input logic [xlen-1:0] pc);
        exu_issue_t t;
        int         kind;
        int         v;
        int         off;
        t = '0;
        kind = int'($urandom_range(0, 19));
        v    = int'($urandom_range(0, 5));
        off  = (int'($urandom_range(0, 31)) - 16) * 4;
        t.pc          = pc;
        t.imm         = $urandom;
        t.rd          = reg_addr_w'($urandom_range(0, 7));
        t.rs1         = reg_addr_w'($urandom_range(0, 7));
        t.rs2         = reg_addr_w'($urandom_range(0, 7));
        t.alu_op      = alu_op_e'(4'($urandom_range(0, 9)));
        t.cmp_op      = cmp_op_e'(3'(v < 2 ? v : v + 2)); // skips the unused codes.
        t.src2_is_imm = 1'($urandom_range(0, 1));
        t.we          = 1'b1;
        if (kind < 12 && kind >= 3) begin
            t.alu_op      = add;
            t.src2_is_imm = 1'b1;
        end
        if (kind < 3) begin
            t.is_load     = 1'b1;
            t.alu_op      = add;
            t.src2_is_imm = 1'b1;
            t.imm         = xlen'($urandom_range(0, 255));
        end else if (kind < 5) begin
            t.we       = 1'b0;
            t.is_store = 1'b1;
        end else if (kind < 8) begin
            t.we         = 1'b0;
            t.flow       = flow_branch;
            t.src1_is_pc = 1'b1;
            t.imm        = xlen'(off);
        end else if (kind == 8) begin
            t.flow       = flow_jal;
            t.src1_is_pc = 1'b1;
            t.imm        = xlen'(off);
        end else if (kind == 9) begin
            t.flow = flow_jalr;
            t.imm  = xlen'(off + 1);
        end else if (kind == 10) begin
            t.we   = 1'b0;
            t.flow = flow_ecall;
        end else if (kind == 11) begin
            t.we   = 1'b0;
            t.flow = flow_mret;
        end
        return t;
    endfunction

    // expected result and redirect for an accepted instruction.
    task automatic model_accept(input exu_issue_t t, output logic push,
                                output logic [xlen-1:0] push_val);
        logic [xlen:0]   s1;
        logic [xlen:0]   s2;
        logic [xlen-1:0] y;
        logic [xlen-1:0] tgt;
        logic            want;
        exu_result_t     e;
        s1   = operand(t.rs1);
        s2   = operand(t.rs2);
        push = 1'b0;
        push_val = '0;
        if (s1[xlen] || s2[xlen]) begin
            report_error("instruction accepted while its source load was still pending");
        end
        if (!m_redir) begin
            y = alu_model(t.alu_op, t.src1_is_pc ? t.pc : s1[xlen-1:0],
                          t.src2_is_imm ? t.imm : s2[xlen-1:0]);
            e.rd         = t.rd;
            e.we         = t.we;
            e.is_load    = t.is_load;
            e.is_store   = t.is_store;
            e.result     = (t.flow == flow_jal || t.flow == flow_jalr) ? t.pc + 32'd4 : y;
            e.store_data = s2[xlen-1:0];
            e.pc         = t.pc;
            exp_q.push_back(e);
            want = t.flow != flow_none;
            tgt  = y;
            case (t.flow)
                flow_branch: want = cmp_model(t.cmp_op, s1[xlen-1:0], s2[xlen-1:0]);
                flow_jalr:   tgt = y & ~32'd1;
                flow_ecall: begin
                    tgt    = m_mtvec;
                    m_mepc = t.pc;
                end
                flow_mret:   tgt = m_mepc;
                default:     tgt = y;
            endcase
            if (want && tgt != t.pc + 32'd4) begin
                m_redir = 1'b1;
                m_redirects++;
                redir_q.push_back(tgt);
            end
            push     = t.we;
            push_val = e.result;
        end
    endtask

    task automatic step();
        logic            accepted;
        logic            push;
        logic [xlen-1:0] push_val;
        accepted = issue_valid && issue_ready;
        push     = 1'b0;
        push_val = '0;
        if (holding && res_valid) begin
            check_result("held result", held, res);
        end
        holding = res_valid && !res_ready;
        held    = res;
        if (res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                report_error("result appeared with no instruction expected");
            end else begin
                check_result("result", exp_q.pop_front(), res);
            end
        end
        if (redirect_valid && redirect_ack) begin
            if (redir_q.size() == 0) begin
                report_error("redirect raised with no taken control flow");
            end else begin
                check_redirect("redirect", redir_q.pop_front(), redirect_pc);
            end
        end
        if (accepted) begin
            model_accept(issue, push, push_val);
        end
        if (load_valid) begin
            fill_load(load_data);
        end
        if (push) begin
            push_hist(issue.rd, push_val, issue.is_load);
        end
        if (redirect_ack) begin
            m_redir = 1'b0;
        end
        if (stream_on && (!issue_valid || accepted)) begin
            if (issued == n_instr) begin
                issue_valid <= 1'b0;
            end else begin
                if (!have_cand) begin
                    cand      = gen_instr(next_pc);
                    have_cand = 1'b1;
                    next_pc   = next_pc + 32'd4;
                end
                // a pending load must not drop out of the history.
                if (cand.we && m_hist[hist_depth-1].valid && m_hist[hist_depth-1].pending) begin
                    issue_valid <= 1'b0;
                end else begin
                    cand.rs1_data = m_rf[cand.rs1];
                    cand.rs2_data = m_rf[cand.rs2];
                    issue       <= cand;
                    issue_valid <= 1'b1;
                    have_cand    = 1'b0;
                    issued++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            step();
        end
    end

    // memory stage.
    initial begin
        forever begin
            @(posedge clk);
            if (res_valid && res_ready && res.is_load) begin
                loads_out++;
            end
            res_ready  <= ($urandom_range(0, 3) != 0);
            load_valid <= 1'b0;
            if (!rst && loads_out > 0 && $urandom_range(0, 2) == 0) begin
                loads_out--;
                load_valid <= 1'b1;
                load_data  <= $urandom;
            end
        end
    end

    // fetch.
    initial begin
        forever begin
            @(posedge clk);
            redirect_ack <= 1'b0;
            if (redirect_valid && !redirect_ack && $urandom_range(0, 3) == 0) begin
                redirect_ack <= 1'b1;
            end
        end
    end

    task automatic apb_write(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [xlen-1:0] addr, output logic [xlen-1:0] data,
                            output logic err);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        checks++;
        if (!pready) begin
            report_error("pready was low in the apb access phase");
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic stream_done();
        return issued == n_instr && !issue_valid && exp_q.size() == 0 && !redirect_valid
            && !m_redir && loads_out == 0 && !load_valid && !hist_has_pending();
    endfunction

    initial begin
        repeat (n_instr * 40 + 2000) @(posedge clk);
        $display("Error: timeout, the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [xlen-1:0] rdata;
        logic            err;
        int              base_checks;
        int              base_errors;
        void'($urandom(seed));
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        res_ready = 1'b0;
        load_valid = 1'b0;
        load_data = '0;
        redirect_ack = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        holding = 1'b0;
        held = '0;
        have_cand = 1'b0;
        stream_on = 1'b0;
        next_pc = 32'h1000;
        loads_out = 0;
        issued = 0;
        checks = 0;
        errors = 0;
        model_reset();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        base_checks = checks;
        base_errors = errors;
        m_mtvec = $urandom & ~32'd3;
        m_mepc  = $urandom & ~32'd3;
        apb_write(reg_mtvec, m_mtvec);
        apb_write(reg_mepc, m_mepc);
        stream_on <= 1'b1;
        while (!stream_done()) @(posedge clk);
        stream_on = 1'b0;
        if (redir_q.size() != 0) begin
            report_error("expected redirect never reached fetch");
        end
        $display("test random_stream: %0d checks, %0d errors",
                 checks - base_checks, errors - base_errors);

        base_checks = checks;
        base_errors = errors;
        apb_read(reg_mtvec, rdata, err);
        check_apb("mtvec read", m_mtvec, rdata);
        if (err) begin
            report_error("pslverr raised on the mtvec read");
        end
        apb_read(reg_mepc, rdata, err);
        check_apb("mepc read", m_mepc, rdata);
        if (err) begin
            report_error("pslverr raised on the mepc read");
        end
        apb_read(reg_redirects, rdata, err);
        check_apb("redirect count", m_redirects, rdata);
        if (err) begin
            report_error("pslverr raised on the redirect count read");
        end
        apb_read(32'hc, rdata, err);
        checks++;
        if (!err) begin
            report_error("unmapped read did not raise pslverr");
        end
        apb_write(reg_redirects, '0);
        m_redirects = '0;
        apb_read(reg_redirects, rdata, err);
        check_apb("redirect count cleared", m_redirects, rdata);
        $display("test trap_regs: %0d checks, %0d errors",
                 checks - base_checks, errors - base_errors);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  exu_pkg::exu_issue_t       issue,
    output logic                      issue_ready,
    output logic                      res_valid,
    output exu_pkg::exu_result_t      res,
    input  logic                      res_ready,
    input  logic                      load_valid,
    input  logic [exu_pkg::xlen-1:0]  load_data,
    output logic                      redirect_valid,
    output logic [exu_pkg::xlen-1:0]  redirect_pc,
    input  logic                      redirect_ack,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [exu_pkg::xlen-1:0]  paddr,
    input  logic [exu_pkg::xlen-1:0]  pwdata,
    output logic [exu_pkg::xlen-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import exu_pkg::*;

    logic [xlen-1:0] fwd1, fwd2;
    logic [xlen-1:0] alu_a, alu_b, alu_y;
    logic [xlen-1:0] link_pc, res_value;
    logic [xlen-1:0] mtvec, mepc, trap_pc;
    logic            stall, taken, redirect_pending;
    logic            res_free, accept, keep;
    logic            trap_take, redirect_fire;
    exu_result_t     res_next;

    assign res_free    = res_ready || !res_valid;
    assign issue_ready = res_free && !stall;
    assign accept      = issue_valid && issue_ready;
    assign keep        = accept && !redirect_pending; // wrong path is consumed, not kept.

    assign alu_a     = issue.src1_is_pc ? issue.pc : fwd1;
    assign alu_b     = issue.src2_is_imm ? issue.imm : fwd2;
    assign link_pc   = issue.pc + xlen'(4);
    assign res_value = (issue.flow == flow_jal || issue.flow == flow_jalr) ? link_pc : alu_y;

    exu_bypass i_exu_bypass (
        .clk(clk), .rst(rst),
        .rs1(issue.rs1), .rs2(issue.rs2),
        .rs1_data(issue.rs1_data), .rs2_data(issue.rs2_data),
        .push(keep && issue.we), .push_rd(issue.rd),
        .push_data(res_value), .push_load(issue.is_load),
        .load_valid(load_valid), .load_data(load_data),
        .fwd1(fwd1), .fwd2(fwd2), .stall(stall)
    );

    exu_alu i_exu_alu (
        .op(issue.alu_op), .cmp_op(issue.cmp_op),
        .a(alu_a), .b(alu_b), .c(fwd1), .d(fwd2),
        .y(alu_y), .taken(taken)
    );

    // branch and jump targets come out of the alu adder.
    exu_redirect i_exu_redirect (
        .clk(clk), .rst(rst), .fire(keep), .flow(issue.flow),
        .taken(taken), .pc(issue.pc), .target(alu_y),
        .mtvec(mtvec), .mepc(mepc), .redirect_ack(redirect_ack),
        .redirect_valid(redirect_pending), .redirect_pc(redirect_pc),
        .redirect_fire(redirect_fire), .trap_take(trap_take), .trap_pc(trap_pc)
    );

    exu_trap_regs i_exu_trap_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .trap_take(trap_take), .trap_pc(trap_pc), .redirect_fire(redirect_fire),
        .mtvec(mtvec), .mepc(mepc)
    );

    assign redirect_valid = redirect_pending;

    always_comb begin
        res_next.rd         = issue.rd;
        res_next.we         = issue.we;
        res_next.is_load    = issue.is_load;
        res_next.is_store   = issue.is_store;
        res_next.result     = res_value;
        res_next.store_data = fwd2;
        res_next.pc         = issue.pc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (res_free) begin
            res_valid <= keep;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res <= '0;
        end else if (keep) begin
            res <= res_next; // held while stalled by res_ready.
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

module exu_trap_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [exu_pkg::xlen-1:0]  paddr,
    input  logic [exu_pkg::xlen-1:0]  pwdata,
    output logic [exu_pkg::xlen-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      trap_take,
    input  logic [exu_pkg::xlen-1:0]  trap_pc,
    input  logic                      redirect_fire,
    output logic [exu_pkg::xlen-1:0]  mtvec,
    output logic [exu_pkg::xlen-1:0]  mepc
);
    import exu_pkg::*;

    logic            access;
    logic            wr;
    logic            mapped;
    logic [xlen-1:0] rd_data;
    logic [xlen-1:0] redirects;

    assign access = psel && penable;
    assign wr     = access && pwrite;

    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (paddr)
            reg_mtvec:     rd_data = mtvec;
            reg_mepc:      rd_data = mepc;
            reg_redirects: rd_data = redirects;
            default:       mapped  = 1'b0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_data : '0;
    assign pready  = 1'b1;              // no wait states.
    assign pslverr = access && !mapped;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec     <= '0;
            mepc      <= '0;
            redirects <= '0;
        end else begin
            if (wr && paddr == reg_mtvec) begin
                mtvec <= pwdata;
            end

            // ecall capture beats software.
            if (trap_take) begin
                mepc <= trap_pc;
            end else if (wr && paddr == reg_mepc) begin
                mepc <= pwdata;
            end

            if (wr && paddr == reg_redirects) begin
                redirects <= '0;
            end else if (redirect_fire) begin
                redirects <= redirects + xlen'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module exu_redirect (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fire,
    input  exu_pkg::flow_e            flow,
    input  logic                      taken,
    input  logic [exu_pkg::xlen-1:0]  pc,
    input  logic [exu_pkg::xlen-1:0]  target,
    input  logic [exu_pkg::xlen-1:0]  mtvec,
    input  logic [exu_pkg::xlen-1:0]  mepc,
    input  logic                      redirect_ack,
    output logic                      redirect_valid,
    output logic [exu_pkg::xlen-1:0]  redirect_pc,
    output logic                      redirect_fire,
    output logic                      trap_take,
    output logic [exu_pkg::xlen-1:0]  trap_pc
);
    import exu_pkg::*;

    logic            want;
    logic [xlen-1:0] tgt;

    always_comb begin
        want = 1'b0;
        tgt  = target;
        case (flow)
            flow_branch: want = taken;
            flow_jal:    want = 1'b1;
            flow_jalr: begin
                want = 1'b1;
                tgt  = {target[xlen-1:1], 1'b0};
            end
            flow_ecall: begin
                want = 1'b1;
                tgt  = mtvec;
            end
            flow_mret: begin
                want = 1'b1;
                tgt  = mepc;
            end
            default: want = 1'b0;
        endcase
    end

    // fall-through target needs no redirect.
    assign redirect_fire = fire && want && (tgt != pc + xlen'(4));
    assign trap_take     = fire && (flow == flow_ecall);
    assign trap_pc       = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else if (redirect_fire) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= tgt;
        end else if (redirect_ack) begin
            redirect_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bypass (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [exu_pkg::reg_addr_w-1:0]  rs1,
    input  logic [exu_pkg::reg_addr_w-1:0]  rs2,
    input  logic [exu_pkg::xlen-1:0]        rs1_data,
    input  logic [exu_pkg::xlen-1:0]        rs2_data,
    input  logic                            push,
    input  logic [exu_pkg::reg_addr_w-1:0]  push_rd,
    input  logic [exu_pkg::xlen-1:0]        push_data,
    input  logic                            push_load,
    input  logic                            load_valid,
    input  logic [exu_pkg::xlen-1:0]        load_data,
    output logic [exu_pkg::xlen-1:0]        fwd1,
    output logic [exu_pkg::xlen-1:0]        fwd2,
    output logic                            stall
);
    import exu_pkg::*;

    hist_entry_t [hist_depth-1:0] hist;       // entry 0 is the youngest.
    hist_entry_t [hist_depth-1:0] hist_fill;
    hist_entry_t [hist_depth-1:0] hist_next;
    logic [3:0]                   lost_loads; // loads shifted out before return.
    logic [3:0]                   lost_next;
    logic                         fill_done;
    logic                         stall1;
    logic                         stall2;

    // youngest match wins, x0 never matches.
    function automatic logic [xlen:0] lookup(
        input hist_entry_t [hist_depth-1:0] h,
        input logic [reg_addr_w-1:0]        rs,
        input logic [xlen-1:0]              rf_data
    );
        logic [xlen:0] r;
        r = {1'b0, rf_data};
        for (int i = hist_depth - 1; i >= 0; i--) begin
            if (h[i].valid && h[i].rd == rs && rs != '0) begin
                r = {h[i].pending, h[i].data};
            end
        end
        return r;
    endfunction

    always_comb begin
        {stall1, fwd1} = lookup(hist, rs1, rs1_data);
        {stall2, fwd2} = lookup(hist, rs2, rs2_data);
    end

    assign stall = stall1 || stall2;

    always_comb begin
        hist_fill = hist;
        fill_done = 1'b0;
        lost_next = lost_loads;
        if (load_valid && lost_loads != '0) begin
            lost_next = lost_loads - 4'd1; // belongs to an entry already gone.
        end else if (load_valid) begin
            for (int i = hist_depth - 1; i >= 0; i--) begin
                if (!fill_done && hist[i].valid && hist[i].pending) begin
                    hist_fill[i].data    = load_data;
                    hist_fill[i].pending = 1'b0;
                    fill_done            = 1'b1;
                end
            end
        end

        hist_next = hist_fill;
        if (push) begin
            if (hist_fill[hist_depth-1].valid && hist_fill[hist_depth-1].pending) begin
                lost_next = lost_next + 4'd1;
            end
            for (int i = hist_depth - 1; i > 0; i--) begin
                hist_next[i] = hist_fill[i-1];
            end
            hist_next[0].valid   = 1'b1;
            hist_next[0].rd      = push_rd;
            hist_next[0].data    = push_load ? '0 : push_data;
            hist_next[0].pending = push_load;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist       <= '0;
            lost_loads <= '0;
        end else begin
            hist       <= hist_next;
            lost_loads <= lost_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  exu_pkg::alu_op_e          op,
    input  exu_pkg::cmp_op_e          cmp_op,
    input  logic [exu_pkg::xlen-1:0]  a,
    input  logic [exu_pkg::xlen-1:0]  b,
    input  logic [exu_pkg::xlen-1:0]  c,
    input  logic [exu_pkg::xlen-1:0]  d,
    output logic [exu_pkg::xlen-1:0]  y,
    output logic                      taken
);
    import exu_pkg::*;

    logic [shamt_w-1:0] shamt;
    logic               a_lt_b;
    logic               a_ltu_b;
    logic               c_lt_d;
    logic               c_ltu_d;

    assign shamt   = b[shamt_w-1:0];
    assign a_lt_b  = $signed(a) < $signed(b);
    assign a_ltu_b = a < b;
    assign c_lt_d  = $signed(c) < $signed(d);
    assign c_ltu_d = c < d;

    always_comb begin
        case (op)
            add:     y = a + b;
            sub:     y = a - b;
            sll:     y = a << shamt;
            slt:     y = {{(xlen-1){1'b0}}, a_lt_b};
            sltu:    y = {{(xlen-1){1'b0}}, a_ltu_b};
            xor_op:  y = a ^ b;
            srl:     y = a >> shamt;
            sra:     y = $unsigned($signed(a) >>> shamt);
            or_op:   y = a | b;
            and_op:  y = a & b;
            default: y = '0;
        endcase
    end

    // branch test on the raw register operands.
    always_comb begin
        case (cmp_op)
            eq:      taken = c == d;
            ne:      taken = c != d;
            lt:      taken = c_lt_d;
            ge:      taken = !c_lt_d;
            ltu:     taken = c_ltu_d;
            geu:     taken = !c_ltu_d;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exu_pkg.sv
`default_nettype none

package exu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int hist_depth = 4;
    localparam int shamt_w    = $clog2(xlen);

    // apb register offsets.
    localparam logic [xlen-1:0] reg_mtvec     = 'h0;
    localparam logic [xlen-1:0] reg_mepc      = 'h4;
    localparam logic [xlen-1:0] reg_redirects = 'h8; // read-only, write clears.

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op
    } alu_op_e;

    // same values as the branch funct3.
    typedef enum logic [2:0] {
        eq  = 3'd0,
        ne  = 3'd1,
        lt  = 3'd4,
        ge  = 3'd5,
        ltu = 3'd6,
        geu = 3'd7
    } cmp_op_e;

    typedef enum logic [2:0] {
        flow_none,
        flow_branch,
        flow_jal,
        flow_jalr,
        flow_ecall,
        flow_mret
    } flow_e;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       rs1_data;   // register file values.
        logic [xlen-1:0]       rs2_data;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
        alu_op_e               alu_op;
        cmp_op_e               cmp_op;
        flow_e                 flow;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
    } exu_issue_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
        logic [xlen-1:0]       result;     // alu value, link or address.
        logic [xlen-1:0]       store_data;
        logic [xlen-1:0]       pc;
    } exu_result_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  pending;    // load not yet returned.
    } hist_entry_t;

endpackage

`default_nettype wire
